/* common/harness_pkg.sv */
// External device harness package
// Bus widths, bus word types and default sizes shared by the harness blocks

package harness_pkg;

  // OBI bus geometry
  localparam int unsigned DATA_WIDTH = 32;
  localparam int unsigned ADDR_WIDTH = 32;
  localparam int unsigned BE_WIDTH   = DATA_WIDTH / 8;

  typedef logic [DATA_WIDTH-1:0] data_t;
  typedef logic [ADDR_WIDTH-1:0] addr_t;
  typedef logic [BE_WIDTH-1:0]   be_t;

  // Slow memory size in words
  localparam int unsigned DEFAULT_MEM_WORDS = 128;

  // Entries in each of the OBI request and response queues
  localparam int unsigned DEFAULT_FIFO_DEPTH = 2;

  // Cycles from switch request to acknowledge
  localparam int unsigned DEFAULT_SWITCH_ACK_LATENCY = 15;

  // Rising GPIO edges per output toggle
  localparam int unsigned DEFAULT_CNT_MAX = 2048;

endpackage

/* slow_mem/obi_fifo.sv */
// OBI request/response FIFO
// Queues requests ahead of the slow memory and returns responses in order
`timescale 1ns/10ps

module obi_fifo #(
  parameter int unsigned FIFO_DEPTH = harness_pkg::DEFAULT_FIFO_DEPTH
) (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               obi_req_i,
  input  logic               obi_we_i,
  input  harness_pkg::addr_t obi_addr_i,
  input  harness_pkg::be_t   obi_be_i,
  input  harness_pkg::data_t obi_wdata_i,
  output logic               obi_gnt_o,
  output logic               obi_rvalid_o,
  output harness_pkg::data_t obi_rdata_o,
  output logic               mem_req_o,
  output logic               mem_we_o,
  output harness_pkg::addr_t mem_addr_o,
  output harness_pkg::be_t   mem_be_o,
  output harness_pkg::data_t mem_wdata_o,
  input  logic               mem_gnt_i,
  input  harness_pkg::data_t mem_rdata_i,
  input  logic               mem_rvalid_i
);

  localparam int unsigned PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(FIFO_DEPTH + 1);

  // Request queue payload
  logic               req_we_q    [FIFO_DEPTH];
  harness_pkg::addr_t req_addr_q  [FIFO_DEPTH];
  harness_pkg::be_t   req_be_q    [FIFO_DEPTH];
  harness_pkg::data_t req_wdata_q [FIFO_DEPTH];
  harness_pkg::data_t resp_data_q [FIFO_DEPTH];

  logic [PTR_W-1:0] req_wptr, req_rptr, resp_wptr, resp_rptr;
  logic [CNT_W-1:0] req_cnt, resp_cnt, out_cnt;
  logic             req_push, req_pop, resp_pop;

  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(FIFO_DEPTH - 1)) return '0;
    return ptr + PTR_W'(1);
  endfunction

  assign obi_gnt_o = obi_req_i && (req_cnt < CNT_W'(FIFO_DEPTH));
  assign req_push  = obi_req_i && obi_gnt_o;

  // Issue only with a response slot reserved for the answer
  assign mem_req_o   = (req_cnt != '0) && (out_cnt < CNT_W'(FIFO_DEPTH));
  assign mem_we_o    = req_we_q[req_rptr];
  assign mem_addr_o  = req_addr_q[req_rptr];
  assign mem_be_o    = req_be_q[req_rptr];
  assign mem_wdata_o = req_wdata_q[req_rptr];
  assign req_pop     = mem_req_o && mem_gnt_i;

  assign obi_rvalid_o = (resp_cnt != '0);
  assign obi_rdata_o  = resp_data_q[resp_rptr];
  assign resp_pop     = obi_rvalid_o;

  always_ff @(posedge clk_i) begin
    if (req_push) begin
      req_we_q[req_wptr]    <= obi_we_i;
      req_addr_q[req_wptr]  <= obi_addr_i;
      req_be_q[req_wptr]    <= obi_be_i;
      req_wdata_q[req_wptr] <= obi_wdata_i;
    end
    if (mem_rvalid_i) begin
      resp_data_q[resp_wptr] <= mem_rdata_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      req_wptr  <= '0;
      req_rptr  <= '0;
      req_cnt   <= '0;
      resp_wptr <= '0;
      resp_rptr <= '0;
      resp_cnt  <= '0;
      out_cnt   <= '0;
    end else begin
      if (req_push) req_wptr <= ptr_next(req_wptr);
      if (req_pop) req_rptr <= ptr_next(req_rptr);
      if (req_push && !req_pop) req_cnt <= req_cnt + CNT_W'(1);
      else if (!req_push && req_pop) req_cnt <= req_cnt - CNT_W'(1);

      if (mem_rvalid_i) resp_wptr <= ptr_next(resp_wptr);
      if (resp_pop) resp_rptr <= ptr_next(resp_rptr);
      if (mem_rvalid_i && !resp_pop) resp_cnt <= resp_cnt + CNT_W'(1);
      else if (!mem_rvalid_i && resp_pop) resp_cnt <= resp_cnt - CNT_W'(1);

      // In flight from memory grant until the response leaves
      if (req_pop && !resp_pop) out_cnt <= out_cnt + CNT_W'(1);
      else if (!req_pop && resp_pop) out_cnt <= out_cnt - CNT_W'(1);
    end
  end

endmodule

/* slow_mem/slow_memory.sv */
// Slow word memory on an OBI port
// LFSR-driven wait states before each grant, read data one cycle after grant
`timescale 1ns/10ps

module slow_memory #(
  parameter int unsigned MEM_WORDS = harness_pkg::DEFAULT_MEM_WORDS
) (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               mem_req_i,
  input  logic               mem_we_i,
  input  harness_pkg::addr_t mem_addr_i,
  input  harness_pkg::be_t   mem_be_i,
  input  harness_pkg::data_t mem_wdata_i,
  output logic               mem_gnt_o,
  output harness_pkg::data_t mem_rdata_o,
  output logic               mem_rvalid_o
);

  localparam int unsigned IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

  harness_pkg::data_t mem_q [MEM_WORDS];

  logic [IDX_W-1:0] word_idx;
  logic [3:0]       lfsr_q;
  logic [1:0]       wait_q;
  logic             grant;

  // Word address above the byte offset
  assign word_idx  = mem_addr_i[IDX_W+1:2];
  assign grant     = mem_req_i && (wait_q == 2'd0);
  assign mem_gnt_o = grant;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      lfsr_q       <= 4'b1001;
      wait_q       <= 2'd0;
      mem_rvalid_o <= 1'b0;
    end else begin
      mem_rvalid_o <= grant;
      if (grant) begin
        // x^4 + x^3 + 1, next wait drawn from the low bits
        lfsr_q <= {lfsr_q[2:0], lfsr_q[3] ^ lfsr_q[2]};
        wait_q <= lfsr_q[1:0];
      end else if (mem_req_i) begin
        wait_q <= wait_q - 2'd1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (grant) begin
      mem_rdata_o <= mem_q[word_idx];
      if (mem_we_i) begin
        for (int b = 0; b < harness_pkg::BE_WIDTH; b++) begin
          if (mem_be_i[b]) mem_q[word_idx][b*8 +: 8] <= mem_wdata_i[b*8 +: 8];
        end
      end
    end
  end

endmodule

/* verilog/power_switch_model.sv */
// Power-switch cell model
// Returns each domain's switch request as its acknowledge after a fixed delay
`timescale 1ns/10ps

module power_switch_model #(
  parameter int unsigned SWITCH_ACK_LATENCY = harness_pkg::DEFAULT_SWITCH_ACK_LATENCY,
  parameter int unsigned NUM_DOMAINS        = 4
) (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic [NUM_DOMAINS-1:0] switch_n_i,
  output logic [NUM_DOMAINS-1:0] switch_ack_n_o
);

  // One stage per cycle of latency, all domains side by side
  logic [NUM_DOMAINS-1:0] ack_pipe_q [SWITCH_ACK_LATENCY];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < SWITCH_ACK_LATENCY; i++) begin
        ack_pipe_q[i] <= '1;
      end
    end else begin
      ack_pipe_q[0] <= switch_n_i;
      for (int i = 1; i < SWITCH_ACK_LATENCY; i++) begin
        ack_pipe_q[i] <= ack_pipe_q[i-1];
      end
    end
  end

  assign switch_ack_n_o = ack_pipe_q[SWITCH_ACK_LATENCY-1];

endmodule

/* verilog/gpio_cnt.sv */
// GPIO edge counter
// Counts rising edges on gpio_i and toggles gpio_o each time the count wraps
`timescale 1ns/10ps

module gpio_cnt #(
  parameter int unsigned CNT_MAX = harness_pkg::DEFAULT_CNT_MAX
) (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic gpio_i,
  output logic gpio_o
);

  localparam int unsigned CNT_W = (CNT_MAX > 1) ? $clog2(CNT_MAX) : 1;

  logic             gpio_q, gpio_prev_q, rise;
  logic [CNT_W-1:0] cnt_q;

  assign rise = gpio_q && !gpio_prev_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      gpio_q      <= 1'b0;
      gpio_prev_q <= 1'b0;
      cnt_q       <= '0;
      gpio_o      <= 1'b0;
    end else begin
      gpio_q      <= gpio_i;
      gpio_prev_q <= gpio_q;
      if (rise) begin
        if (cnt_q == CNT_W'(CNT_MAX - 1)) begin
          cnt_q  <= '0;
          gpio_o <= !gpio_o;
        end else begin
          cnt_q <= cnt_q + CNT_W'(1);
        end
      end
    end
  end

endmodule

/* verilog/ext_harness.sv */
// External device harness
// Slow OBI memory behind a FIFO, power-switch acknowledge model and GPIO counter
`timescale 1ns/10ps

module ext_harness #(
  parameter int unsigned MEM_WORDS          = harness_pkg::DEFAULT_MEM_WORDS,
  parameter int unsigned FIFO_DEPTH         = harness_pkg::DEFAULT_FIFO_DEPTH,
  parameter int unsigned SWITCH_ACK_LATENCY = harness_pkg::DEFAULT_SWITCH_ACK_LATENCY,
  parameter int unsigned NUM_DOMAINS        = 4,
  parameter int unsigned CNT_MAX            = harness_pkg::DEFAULT_CNT_MAX
) (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   obi_req_i,
  input  logic                   obi_we_i,
  input  harness_pkg::addr_t     obi_addr_i,
  input  harness_pkg::be_t       obi_be_i,
  input  harness_pkg::data_t     obi_wdata_i,
  output logic                   obi_gnt_o,
  output logic                   obi_rvalid_o,
  output harness_pkg::data_t     obi_rdata_o,
  input  logic [NUM_DOMAINS-1:0] switch_n_i,
  output logic [NUM_DOMAINS-1:0] switch_ack_n_o,
  input  logic                   gpio_i,
  output logic                   gpio_o
);

  // FIFO to slow memory
  logic               mem_req;
  logic               mem_we;
  harness_pkg::addr_t mem_addr;
  harness_pkg::be_t   mem_be;
  harness_pkg::data_t mem_wdata;
  logic               mem_gnt;
  harness_pkg::data_t mem_rdata;
  logic               mem_rvalid;

  obi_fifo #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) obi_fifo_i (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .obi_req_i   (obi_req_i),
    .obi_we_i    (obi_we_i),
    .obi_addr_i  (obi_addr_i),
    .obi_be_i    (obi_be_i),
    .obi_wdata_i (obi_wdata_i),
    .obi_gnt_o   (obi_gnt_o),
    .obi_rvalid_o(obi_rvalid_o),
    .obi_rdata_o (obi_rdata_o),
    .mem_req_o   (mem_req),
    .mem_we_o    (mem_we),
    .mem_addr_o  (mem_addr),
    .mem_be_o    (mem_be),
    .mem_wdata_o (mem_wdata),
    .mem_gnt_i   (mem_gnt),
    .mem_rdata_i (mem_rdata),
    .mem_rvalid_i(mem_rvalid)
  );

  slow_memory #(
    .MEM_WORDS(MEM_WORDS)
  ) slow_ram_i (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .mem_req_i   (mem_req),
    .mem_we_i    (mem_we),
    .mem_addr_i  (mem_addr),
    .mem_be_i    (mem_be),
    .mem_wdata_i (mem_wdata),
    .mem_gnt_o   (mem_gnt),
    .mem_rdata_o (mem_rdata),
    .mem_rvalid_o(mem_rvalid)
  );

  power_switch_model #(
    .SWITCH_ACK_LATENCY(SWITCH_ACK_LATENCY),
    .NUM_DOMAINS       (NUM_DOMAINS)
  ) power_switch_model_i (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .switch_n_i    (switch_n_i),
    .switch_ack_n_o(switch_ack_n_o)
  );

  gpio_cnt #(
    .CNT_MAX(CNT_MAX)
  ) gpio_cnt_i (
    .clk_i  (clk_i),
    .rst_n_i(rst_n_i),
    .gpio_i (gpio_i),
    .gpio_o (gpio_o)
  );

endmodule

/* sim/ext_harness_assert.sv */
// Harness bus assertions
// Request stability, response count and switch acknowledge state in reset
`timescale 1ns/10ps

module ext_harness_assert #(
  parameter int unsigned NUM_DOMAINS = 4
) (
  input logic                   clk_i,
  input logic                   rst_n_i,
  input logic                   req_i,
  input logic                   we_i,
  input harness_pkg::addr_t     addr_i,
  input harness_pkg::be_t       be_i,
  input harness_pkg::data_t     wdata_i,
  input logic                   gnt_i,
  input logic                   rvalid_i,
  input logic [NUM_DOMAINS-1:0] ack_n_i
);

  int unsigned owed;
  int unsigned fail_cnt = 0;

  // Grants still waiting for their response
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      owed <= 0;
    end else begin
      owed <= owed + 32'(req_i && gnt_i) - 32'(rvalid_i);
    end
  end

  req_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    req_i && !gnt_i |=> req_i && $stable({we_i, addr_i, be_i, wdata_i}))
  else begin
    $error("OBI request changed or dropped before it was granted");
    fail_cnt++;
  end

  resp_owed: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rvalid_i |-> owed != 0)
  else begin
    $error("OBI response without an outstanding grant");
    fail_cnt++;
  end

  ack_in_reset: assert property (@(posedge clk_i) !rst_n_i |-> &ack_n_i)
  else begin
    $error("switch acknowledge not all ones during reset");
    fail_cnt++;
  end

endmodule

bind ext_harness ext_harness_assert #(
  .NUM_DOMAINS(NUM_DOMAINS)
) assert0 (
  .clk_i   (clk_i),
  .rst_n_i (rst_n_i),
  .req_i   (obi_req_i),
  .we_i    (obi_we_i),
  .addr_i  (obi_addr_i),
  .be_i    (obi_be_i),
  .wdata_i (obi_wdata_i),
  .gnt_i   (obi_gnt_o),
  .rvalid_i(obi_rvalid_o),
  .ack_n_i (switch_ack_n_o)
);

/* sim/ext_harness_checker.sv */
// Harness response checker
// Matches OBI responses in order, times switch acknowledges, checks GPIO and reset state
`timescale 1ns/10ps

module ext_harness_checker #(
  parameter int unsigned NUM_DOMAINS        = 4,
  parameter int unsigned SWITCH_ACK_LATENCY = 15
) (
  input logic                   clk_i,
  input logic                   rst_n_i,
  input logic                   gnt_i,
  input logic                   rvalid_i,
  input harness_pkg::data_t     rdata_i,
  input logic [NUM_DOMAINS-1:0] ack_n_i,
  input logic                   gpio_out_i
);

  string                  resp_name [$];
  bit                     resp_check [$];
  logic [31:0]            resp_exp [$];
  int unsigned            pending = 0;
  int unsigned            peak = 0;
  int unsigned            test_count = 0;
  int unsigned            fail_count = 0;
  string                  sw_name;
  logic [NUM_DOMAINS-1:0] sw_old;
  logic [NUM_DOMAINS-1:0] sw_new;
  int unsigned            sw_cnt = 0;
  bit                     sw_busy = 1'b0;

  task automatic finish_test(input string name, input bit ok, input logic [31:0] exp,
                             input logic [31:0] act);
    test_count++;
    if (ok) begin
      $display("Test %s: ok", name);
    end else begin
      fail_count++;
      $display("Error in test %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic note_failure(input string name, input string msg);
    test_count++;
    fail_count++;
    $display("Test %s failed: %s", name, msg);
  endtask

  task automatic expect_resp(input string name, input bit check, input logic [31:0] exp);
    // Peak covers the current stretch of overlapping requests
    if (pending == 0) peak = 0;
    resp_name.push_back(name);
    resp_check.push_back(check);
    resp_exp.push_back(exp);
    pending++;
    if (pending > peak) peak = pending;
  endtask

  task automatic expect_switch(input string name, input logic [NUM_DOMAINS-1:0] old_val,
                               input logic [NUM_DOMAINS-1:0] new_val);
    sw_name = name;
    sw_old  = old_val;
    sw_new  = new_val;
    sw_cnt  = 0;
    sw_busy = 1'b1;
  endtask

  task automatic check_reset(input string name, input logic [NUM_DOMAINS-1:0] exp_ack);
    logic [31:0] exp;
    logic [31:0] act;
    exp = 32'({3'b000, exp_ack});
    act = 32'({gnt_i, rvalid_i, gpio_out_i, ack_n_i});
    finish_test(name, act === exp, exp, act);
  endtask

  task automatic check_gpio(input string name, input logic exp);
    finish_test(name, gpio_out_i === exp, 32'(exp), 32'(gpio_out_i));
  endtask

  task automatic check_peak(input string name, input int unsigned min_peak);
    finish_test(name, peak >= min_peak, min_peak, peak);
  endtask

  task automatic print_counts();
    $display("Checks: %0d run, %0d passed, %0d failed",
             test_count, test_count - fail_count, fail_count);
  endtask

  always @(posedge clk_i) begin : response_match
    string       name;
    bit          check;
    logic [31:0] exp;
    if (rst_n_i && rvalid_i) begin
      if (pending == 0) begin
        note_failure("obi", "a response arrived with no request outstanding");
      end else begin
        name  = resp_name.pop_front();
        check = resp_check.pop_front();
        exp   = resp_exp.pop_front();
        pending--;
        finish_test(name, !check || (rdata_i === exp), exp, rdata_i);
      end
    end
  end

  // Old value one cycle before the latency is up, new value right at it
  always @(posedge clk_i) begin
    if (sw_busy) begin
      sw_cnt++;
      if (sw_cnt == SWITCH_ACK_LATENCY && ack_n_i !== sw_old) begin
        finish_test(sw_name, 1'b0, 32'(sw_old), 32'(ack_n_i));
        sw_busy = 1'b0;
      end else if (sw_cnt == SWITCH_ACK_LATENCY + 1) begin
        finish_test(sw_name, ack_n_i === sw_new, 32'(sw_new), 32'(ack_n_i));
        sw_busy = 1'b0;
      end
    end
  end

endmodule

/* sim/tb_ext_harness.sv */
// External device harness testbench
// Clock, reset, stimulus file reader, watchdog and DUT with its checker
`timescale 1ns/10ps

module tb_ext_harness;

  localparam int unsigned NUM_DOMAINS        = 4;
  localparam int unsigned SWITCH_ACK_LATENCY = 15;
  localparam int unsigned CNT_MAX            = 16;
  localparam int unsigned MEM_WORDS          = harness_pkg::DEFAULT_MEM_WORDS;

  logic                   clk_i;
  logic                   rst_n_i;
  logic                   obi_req_i;
  logic                   obi_we_i;
  harness_pkg::addr_t     obi_addr_i;
  harness_pkg::be_t       obi_be_i;
  harness_pkg::data_t     obi_wdata_i;
  logic                   obi_gnt_o;
  logic                   obi_rvalid_o;
  harness_pkg::data_t     obi_rdata_o;
  logic [NUM_DOMAINS-1:0] switch_n_i;
  logic [NUM_DOMAINS-1:0] switch_ack_n_o;
  logic                   gpio_i;
  logic                   gpio_o;

  string                  st_name [$];
  string                  st_op [$];
  logic [31:0]            st_addr [$];
  logic [31:0]            st_be [$];
  logic [31:0]            st_data [$];
  logic [31:0]            st_exp [$];
  logic [31:0]            model [int unsigned];
  logic [NUM_DOMAINS-1:0] sw_prev;
  int                     seed;
  bit                     loaded = 1'b0;

  ext_harness #(
    .SWITCH_ACK_LATENCY(SWITCH_ACK_LATENCY),
    .NUM_DOMAINS       (NUM_DOMAINS),
    .CNT_MAX           (CNT_MAX)
  ) dut0 (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .obi_req_i     (obi_req_i),
    .obi_we_i      (obi_we_i),
    .obi_addr_i    (obi_addr_i),
    .obi_be_i      (obi_be_i),
    .obi_wdata_i   (obi_wdata_i),
    .obi_gnt_o     (obi_gnt_o),
    .obi_rvalid_o  (obi_rvalid_o),
    .obi_rdata_o   (obi_rdata_o),
    .switch_n_i    (switch_n_i),
    .switch_ack_n_o(switch_ack_n_o),
    .gpio_i        (gpio_i),
    .gpio_o        (gpio_o)
  );

  ext_harness_checker #(
    .NUM_DOMAINS       (NUM_DOMAINS),
    .SWITCH_ACK_LATENCY(SWITCH_ACK_LATENCY)
  ) checker0 (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .gnt_i     (obi_gnt_o),
    .rvalid_i  (obi_rvalid_o),
    .rdata_i   (obi_rdata_o),
    .ack_n_i   (switch_ack_n_o),
    .gpio_out_i(gpio_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                              input logic [31:0] new_word,
                                              input logic [3:0] be);
    logic [31:0] word;
    word = old_word;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) word[b*8 +: 8] = new_word[b*8 +: 8];
    end
    return word;
  endfunction

  task automatic load_stimulus();
    int          fd;
    int          n;
    string       line;
    string       name;
    string       op;
    logic [31:0] a, b, d, e;
    fd = $fopen("sim/ext_harness_stimulus.txt", "r");
    if (fd == 0) begin
      checker0.note_failure("stimulus", "cannot open sim/ext_harness_stimulus.txt");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        if (n > 1 && line.getc(0) != "#") begin
          n = $sscanf(line, "%s %s %h %h %h %h", name, op, a, b, d, e);
          if (n == 6) begin
            st_name.push_back(name);
            st_op.push_back(op);
            st_addr.push_back(a);
            st_be.push_back(b);
            st_data.push_back(d);
            st_exp.push_back(e);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // Hold the request until granted, then register the expected response
  task automatic send(input string name, input logic we, input logic [31:0] addr,
                      input logic [3:0] be, input logic [31:0] wdata, input bit check,
                      input logic [31:0] exp);
    @(negedge clk_i);
    obi_req_i   = 1'b1;
    obi_we_i    = we;
    obi_addr_i  = addr;
    obi_be_i    = be;
    obi_wdata_i = wdata;
    #1;
    while (!obi_gnt_o) begin
      @(negedge clk_i);
      #1;
    end
    checker0.expect_resp(name, check, exp);
  endtask

  task automatic gap();
    int n;
    n = 1 + ($unsigned($random(seed)) % 3);
    @(negedge clk_i);
    obi_req_i = 1'b0;
    obi_we_i  = 1'b0;
    repeat (n - 1) @(negedge clk_i);
  endtask

  task automatic run_op(input int i);
    string       name;
    string       op;
    logic [31:0] a, b, d, e;
    int unsigned idx;
    name = st_name[i];
    op   = st_op[i];
    a    = st_addr[i];
    b    = st_be[i];
    d    = st_data[i];
    e    = st_exp[i];
    idx  = (a >> 2) % MEM_WORDS;
    if (op == "reset") begin
      @(negedge clk_i);
      checker0.check_reset(name, e[NUM_DOMAINS-1:0]);
    end else if (op == "write") begin
      model[idx] = merge_bytes(model.exists(idx) ? model[idx] : '0, d, b[3:0]);
      send(name, 1'b1, a, b[3:0], d, 1'b0, '0);
      gap();
    end else if (op == "read" || op == "bread") begin
      if (!model.exists(idx)) begin
        checker0.note_failure(name, "read of a word that was never written");
      end else if (model[idx] !== e) begin
        checker0.note_failure(name, "stimulus expectation differs from the memory model");
      end
      send(name, 1'b0, a, 4'hf, '0, 1'b1, e);
      if (op == "read" || i + 1 >= st_op.size() || st_op[i+1] != "bread") gap();
    end else if (op == "peak") begin
      wait (checker0.pending == 0);
      checker0.check_peak(name, e);
    end else if (op == "switch") begin
      @(negedge clk_i);
      switch_n_i = d[NUM_DOMAINS-1:0];
      checker0.expect_switch(name, sw_prev, e[NUM_DOMAINS-1:0]);
      sw_prev = d[NUM_DOMAINS-1:0];
      wait (!checker0.sw_busy);
      gap();
    end else if (op == "gpio") begin
      repeat (d) begin
        @(negedge clk_i);
        gpio_i = 1'b1;
        repeat (2) @(negedge clk_i);
        gpio_i = 1'b0;
        @(negedge clk_i);
      end
      repeat (2) @(negedge clk_i);
      checker0.check_gpio(name, e[0]);
    end else begin
      checker0.note_failure(name, {"unknown operation ", op});
    end
  endtask

  initial begin : watchdog
    int unsigned limit;
    wait (loaded);
    limit = (st_name.size() > 0) ? st_name.size() * 200 : 200;
    repeat (limit) @(posedge clk_i);
    $display("Timeout: the run did not finish within %0d cycles", limit);
    $display("SOME TESTS FAILED");
    $finish;
  end

  initial begin : main
    rst_n_i     = 1'b1;
    obi_req_i   = 1'b0;
    obi_we_i    = 1'b0;
    obi_addr_i  = '0;
    obi_be_i    = '0;
    obi_wdata_i = '0;
    switch_n_i  = '1;
    gpio_i      = 1'b0;
    seed        = 87;
    sw_prev     = '1;
    load_stimulus();
    loaded = 1'b1;
    #1 rst_n_i = 1'b0;
    repeat (16) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;
    foreach (st_name[i]) run_op(i);
    wait (checker0.pending == 0 && !checker0.sw_busy);
    repeat (2) @(negedge clk_i);
    checker0.print_counts();
    if (checker0.fail_count == 0 && dut0.assert0.fail_cnt == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

/* sim/ext_harness_stimulus.txt */
# name          op      addr      be  data      expect
# addr, be, data and expect in hex; unused columns are 0; gpio data is the pulse count
reset_state     reset   00000000  0   00000000  0000000f
wr_full_a       write   00000010  f   deadbeef  00000000
rd_full_a       read    00000010  f   00000000  deadbeef
wr_full_b       write   00000024  f   01234567  00000000
wr_part_lo      write   00000024  3   0000abcd  00000000
rd_part_lo      read    00000024  f   00000000  0123abcd
wr_part_hi      write   00000024  8   ee000000  00000000
rd_part_hi      read    00000024  f   00000000  ee23abcd
rd_alias        read    00000210  f   00000000  deadbeef
wr_b0           write   00000040  f   11111111  00000000
wr_b1           write   00000044  f   22222222  00000000
wr_b2           write   00000048  f   33333333  00000000
wr_b3           write   0000004c  f   44444444  00000000
burst_0         bread   0000004c  f   00000000  44444444
burst_1         bread   00000040  f   00000000  11111111
burst_2         bread   00000048  f   00000000  33333333
burst_3         bread   00000044  f   00000000  22222222
burst_4         bread   00000024  f   00000000  ee23abcd
burst_overlap   peak    00000000  0   00000000  00000002
sw_dom0         switch  00000000  0   0000000e  0000000e
sw_dom1         switch  00000000  0   0000000c  0000000c
sw_dom2         switch  00000000  0   00000008  00000008
sw_dom3         switch  00000000  0   00000000  00000000
sw_all_off      switch  00000000  0   0000000f  0000000f
sw_mixed        switch  00000000  0   00000005  00000005
gpio_15         gpio    00000000  0   0000000f  00000000
gpio_16         gpio    00000000  0   00000001  00000001
gpio_32         gpio    00000000  0   00000010  00000000

/* ext_harness.f */
common/harness_pkg.sv
slow_mem/obi_fifo.sv
slow_mem/slow_memory.sv
verilog/power_switch_model.sv
verilog/gpio_cnt.sv
verilog/ext_harness.sv
sim/ext_harness_assert.sv
sim/ext_harness_checker.sv
sim/tb_ext_harness.sv

/* Makefile */
OBJ := obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f ext_harness.f \
		--top-module tb_ext_harness -Mdir $(OBJ) -o sim_ext_harness

run: compile
	./$(OBJ)/sim_ext_harness > sim.log 2>&1; cat sim.log
	grep -q "ALL TESTS PASSED" sim.log

clean:
	rm -rf $(OBJ) sim.log
